//--- Makefile
# Verilator build and run for the up_subsystem testbench.
TOP = up_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP) -f up_subsystem.f

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "^Result: PASSED$$" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- common/up_pkg.sv
// Host byte type, register bus structs, packet layout, command bits and status codes.
package up_pkg;

   typedef logic [7:0] byte_t;

   // Interface to slave.
   typedef struct packed {
      logic        rw;             // 1 = write.
      logic [7:0]  reg_address;
      logic [31:0] wdata;
      logic        handshake_1;    // Request phase.
   } bus_req_t;

   // Slave to interface.
   typedef struct packed {
      logic [31:0] rdata;
      logic        error;
      logic        handshake_2;    // Response phase.
   } bus_rsp_t;

   // Packet lengths in bytes.
   localparam int NOS_READ_BYTES  = 6;   // Command from host.
   localparam int NOS_WRITE_BYTES = 5;   // Reply to host.

   // Command packet layout.
   localparam int CMD_REG         = 0;
   localparam int REGISTER_NUMBER = 1;
   localparam int DATA_LSB        = 2;   // Write data, LSB first.

   // Reply packet starts with the status byte.
   localparam int UP_STATUS_REG   = 0;

   // Command byte bits.
   localparam int RW_BIT    = 0;
   localparam int RESET_BIT = 7;

   // Status codes.
   localparam byte_t CMD_DONE       = 8'h01;
   localparam byte_t CMD_ERROR      = 8'h02;
   localparam byte_t RESET_CMD_DONE = 8'h80;

   localparam int NUM_REGS = 8;

endpackage

//--- hdl/reg_bank.sv
// Register-bank bus slave with eight 32-bit registers and range checking.
module reg_bank
   import up_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  bus_req_t bus_req,
   output bus_rsp_t bus_rsp
);

   logic [31:0] regs [NUM_REGS];
   logic [$clog2(NUM_REGS)-1:0] idx;
   logic        in_range;
   logic        start;
   logic        handshake_2;
   logic [31:0] rdata;
   logic        error;

   assign idx      = bus_req.reg_address[$clog2(NUM_REGS)-1:0];
   assign in_range = (bus_req.reg_address < 8'(NUM_REGS));
   assign start    = bus_req.handshake_1 && !handshake_2;  // Rising request.

   // Response phase trails the request by one cycle both ways.
   always_ff @(posedge clk) begin
      if (!reset)
         handshake_2 <= 1'b0;
      else
         handshake_2 <= bus_req.handshake_1;
   end

   always_ff @(posedge clk) begin
      if (!reset)
         regs <= '{default: '0};
      else if (start && in_range && bus_req.rw)
         regs[idx] <= bus_req.wdata;
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rdata <= in_range ? regs[idx] : 32'h0;  // Old value on a write.
         error <= !in_range;
      end
   end

   assign bus_rsp.rdata       = rdata;
   assign bus_rsp.error       = error;
   assign bus_rsp.handshake_2 = handshake_2;

endmodule

//--- hdl/up_subsystem.sv
// Top level joining the host control port to the register bank.
module up_subsystem
   import up_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  up_start,
   input  logic  up_handshake_1,
   input  byte_t up_data_out,
   output logic  up_ack,
   output logic  up_handshake_2,
   output byte_t up_data_in
);

   bus_req_t bus_req;
   bus_rsp_t bus_rsp;

   up_interface u_up_interface (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_data_out    (up_data_out),
      .bus_rsp        (bus_rsp),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_in     (up_data_in),
      .bus_req        (bus_req)
   );

   reg_bank u_reg_bank (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

endmodule

//--- up_interface/up_interface.sv
// Host-side datapath with packet stores, byte counter and bus field assembly.
module up_interface
   import up_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     up_start,
   input  logic     up_handshake_1,
   input  byte_t    up_data_out,
   input  bus_rsp_t bus_rsp,
   output logic     up_ack,
   output logic     up_handshake_2,
   output byte_t    up_data_in,
   output bus_req_t bus_req
);

   logic counter_zero;
   logic up_soft_reset;
   logic set_in_byte_count, set_out_byte_count;
   logic read_up_byte, write_up_byte;
   logic read_bus_word, clear_up_packet;
   logic bus_handshake_1;

   logic [2:0] counter;       // Byte index into the active packet.
   logic [2:0] target_count;  // Bytes still to move.
   byte_t      data_in_reg;

   byte_t input_packet  [NOS_READ_BYTES];
   byte_t output_packet [NOS_WRITE_BYTES];

   up_interface_fsm u_fsm (
      .clk                (clk),
      .reset              (reset),
      .up_start           (up_start),
      .up_handshake_1     (up_handshake_1),
      .counter_zero       (counter_zero),
      .up_soft_reset      (up_soft_reset),
      .bus_handshake_2    (bus_rsp.handshake_2),
      .up_ack             (up_ack),
      .up_handshake_2     (up_handshake_2),
      .bus_handshake_1    (bus_handshake_1),
      .set_in_byte_count  (set_in_byte_count),
      .set_out_byte_count (set_out_byte_count),
      .read_up_byte       (read_up_byte),
      .write_up_byte      (write_up_byte),
      .read_bus_word      (read_bus_word),
      .clear_up_packet    (clear_up_packet)
   );

   always_ff @(posedge clk) begin
      if (!reset) begin
         counter       <= '0;
         target_count  <= '0;
         input_packet  <= '{default: '0};
         output_packet <= '{default: '0};
      end else if (set_in_byte_count) begin
         counter      <= '0;
         target_count <= 3'(NOS_READ_BYTES);
      end else if (set_out_byte_count) begin
         counter      <= '0;
         target_count <= 3'(NOS_WRITE_BYTES);
      end else if (read_up_byte) begin
         input_packet[counter] <= up_data_out;
         counter               <= counter + 3'd1;
         target_count          <= target_count - 3'd1;
      end else if (write_up_byte) begin
         counter      <= counter + 3'd1;
         target_count <= target_count - 3'd1;
      end else if (read_bus_word) begin
         // Word goes out LSB first behind the status byte.
         output_packet[UP_STATUS_REG + 1] <= bus_rsp.rdata[7:0];
         output_packet[UP_STATUS_REG + 2] <= bus_rsp.rdata[15:8];
         output_packet[UP_STATUS_REG + 3] <= bus_rsp.rdata[23:16];
         output_packet[UP_STATUS_REG + 4] <= bus_rsp.rdata[31:24];
         output_packet[UP_STATUS_REG]     <= bus_rsp.error ? CMD_ERROR : CMD_DONE;
      end else if (clear_up_packet) begin
         output_packet[UP_STATUS_REG] <= RESET_CMD_DONE;  // Data bytes left as they were.
         counter      <= '0;
         target_count <= 3'(NOS_WRITE_BYTES);
      end
   end

   // Reply byte register.
   always_ff @(posedge clk) begin
      if (write_up_byte)
         data_in_reg <= output_packet[counter];
   end

   assign counter_zero  = (target_count == 3'd0);
   assign up_soft_reset = input_packet[CMD_REG][RESET_BIT];
   assign up_data_in    = data_in_reg;

   assign bus_req.rw          = input_packet[CMD_REG][RW_BIT];
   assign bus_req.reg_address = input_packet[REGISTER_NUMBER];
   assign bus_req.wdata       = {input_packet[DATA_LSB + 3], input_packet[DATA_LSB + 2],
                                 input_packet[DATA_LSB + 1], input_packet[DATA_LSB]};
   assign bus_req.handshake_1 = bus_handshake_1;

endmodule

//--- up_interface/up_interface_fsm.sv
// Sequencer for host start/ack, host byte handshakes and the bus handshake.
module up_interface_fsm (
   input  logic clk,
   input  logic reset,
   input  logic up_start,
   input  logic up_handshake_1,
   input  logic counter_zero,
   input  logic up_soft_reset,
   input  logic bus_handshake_2,
   output logic up_ack,
   output logic up_handshake_2,
   output logic bus_handshake_1,
   output logic set_in_byte_count,
   output logic set_out_byte_count,
   output logic read_up_byte,
   output logic write_up_byte,
   output logic read_bus_word,
   output logic clear_up_packet
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_ACK,
      S_IN_WAIT,     // Waiting for host strobe.
      S_IN_ACK,      // Byte taken, waiting for host release.
      S_BUS_REQ,
      S_BUS_REL,
      S_REPLY_LOAD,
      S_REPLY_HS,
      S_DONE
   } state_t;

   state_t state, next_state;

   always_ff @(posedge clk) begin
      if (!reset)
         state <= S_IDLE;
      else
         state <= next_state;
   end

   always_comb begin
      next_state         = state;
      set_in_byte_count  = 1'b0;
      set_out_byte_count = 1'b0;
      read_up_byte       = 1'b0;
      write_up_byte      = 1'b0;
      read_bus_word      = 1'b0;
      clear_up_packet    = 1'b0;

      case (state)
         S_IDLE: begin
            if (up_start)
               next_state = S_ACK;
         end
         S_ACK: begin
            if (!up_start) begin
               set_in_byte_count = 1'b1;
               next_state        = S_IN_WAIT;
            end
         end
         S_IN_WAIT: begin
            if (up_handshake_1) begin
               read_up_byte = 1'b1;  // Byte stored on first sight of strobe.
               next_state   = S_IN_ACK;
            end
         end
         S_IN_ACK: begin
            if (!up_handshake_1) begin
               if (!counter_zero) begin
                  next_state = S_IN_WAIT;
               end else if (up_soft_reset) begin
                  clear_up_packet = 1'b1;  // Bus skipped.
                  next_state      = S_REPLY_LOAD;
               end else begin
                  next_state = S_BUS_REQ;
               end
            end
         end
         S_BUS_REQ: begin
            if (bus_handshake_2) begin
               read_bus_word = 1'b1;
               next_state    = S_BUS_REL;
            end
         end
         S_BUS_REL: begin
            if (!bus_handshake_2) begin
               set_out_byte_count = 1'b1;
               next_state         = S_REPLY_LOAD;
            end
         end
         S_REPLY_LOAD: begin
            // Previous byte must be released first.
            if (!up_handshake_1) begin
               write_up_byte = 1'b1;
               next_state    = S_REPLY_HS;
            end
         end
         S_REPLY_HS: begin
            if (up_handshake_1)
               next_state = counter_zero ? S_DONE : S_REPLY_LOAD;
         end
         S_DONE: begin
            if (!up_handshake_1)
               next_state = S_IDLE;
         end
         default: next_state = S_IDLE;
      endcase
   end

   // Handshake outputs follow the state.
   assign up_ack          = (state == S_ACK);
   assign up_handshake_2  = (state == S_IN_ACK) || (state == S_REPLY_HS);
   assign bus_handshake_1 = (state == S_BUS_REQ);

endmodule

//--- up_subsystem.f
common/up_pkg.sv
up_interface/up_interface_fsm.sv
up_interface/up_interface.sv
hdl/reg_bank.sv
hdl/up_subsystem.sv
verif/up_subsystem_checker.sv
verif/up_subsystem_tb.sv

//--- verif/up_subsystem_checker.sv
// Bound handshake-order assertions for the host port and the register bus.
module up_subsystem_checker
   import up_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input logic     up_start,
   input logic     up_ack,
   input logic     up_handshake_1,
   input logic     up_handshake_2,
   input bus_req_t bus_req,
   input bus_rsp_t bus_rsp
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count = 0;

   // Host strobe settled before the port answers.
   hs2_rise_steady: assert property (@(posedge clk) disable iff (!reset)
      $rose(up_handshake_2) |-> $stable(up_handshake_1))
      else begin
         $error("up_handshake_2 rose while up_handshake_1 was changing");
         fail_count++;
      end

   bus_rsp_follows_rise: assert property (@(posedge clk) disable iff (!reset)
      $rose(bus_req.handshake_1) |=> $rose(bus_rsp.handshake_2))
      else begin
         $error("bus handshake_2 did not rise one cycle after handshake_1");
         fail_count++;
      end

   bus_rsp_follows_fall: assert property (@(posedge clk) disable iff (!reset)
      $fell(bus_req.handshake_1) |=> $fell(bus_rsp.handshake_2))
      else begin
         $error("bus handshake_2 did not fall one cycle after handshake_1");
         fail_count++;
      end

   ack_after_start: assert property (@(posedge clk) disable iff (!reset)
      $fell(up_ack) |-> !$past(up_start))  // Start released first.
      else begin
         $error("up_ack fell before up_start was released");
         fail_count++;
      end

endmodule

bind up_subsystem up_subsystem_checker u_checker (
   .clk            (clk),
   .reset          (reset),
   .up_start       (up_start),
   .up_ack         (up_ack),
   .up_handshake_1 (up_handshake_1),
   .up_handshake_2 (up_handshake_2),
   .bus_req        (bus_req),
   .bus_rsp        (bus_rsp)
);

//--- verif/up_subsystem_tb.sv
// Testbench with clock, reset, host model, register model, reply checks and timeout.
module up_subsystem_tb
   import up_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_DIRECTED   = 9;
   localparam int NUM_RANDOM     = 30;
   localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 200;

   logic  clk;
   logic  reset;
   logic  up_start;
   logic  up_handshake_1;
   byte_t up_data_out;
   logic  up_ack;
   logic  up_handshake_2;
   byte_t up_data_in;

   logic [15:0] lfsr;
   logic [31:0] model_regs [NUM_REGS];
   logic [31:0] last_data;           // Data bytes of the previous reply.
   int          errors;
   int          checks;
   int          cycles = 0;

   up_subsystem UUT (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_data_out    (up_data_out),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .up_data_in     (up_data_in)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a host handshake never completed", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   // Taps 16, 14, 13, 11.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr  = {lfsr[14:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   task automatic idle_gap();
      int n;
      n = int'(rand_bits(2));
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_ack(input logic level);
      @(negedge clk);
      while (up_ack !== level)
         @(negedge clk);
   endtask

   task automatic wait_hs2(input logic level);
      @(negedge clk);
      while (up_handshake_2 !== level)
         @(negedge clk);
   endtask

   task automatic start_packet();
      idle_gap();
      @(posedge clk);
      up_start <= 1'b1;
      wait_ack(1'b1);
      @(posedge clk);
      up_start <= 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic send_byte(input byte_t value);
      idle_gap();
      @(posedge clk);
      up_data_out    <= value;
      up_handshake_1 <= 1'b1;
      wait_hs2(1'b1);
      @(posedge clk);
      up_handshake_1 <= 1'b0;
      wait_hs2(1'b0);
   endtask

   task automatic take_byte(output byte_t value);
      wait_hs2(1'b1);
      value = up_data_in;            // Loaded before the strobe rose.
      idle_gap();
      @(posedge clk);
      up_handshake_1 <= 1'b1;
      wait_hs2(1'b0);
      @(posedge clk);
      up_handshake_1 <= 1'b0;
   endtask

   task automatic check_byte(input int index, input byte_t got, input byte_t expected);
      checks++;
      assert (got === expected)
      else begin
         errors++;
         $display("FAILED up_data_in byte %0d: got 0x%h, expected 0x%h", index, got, expected);
      end
   endtask

   task automatic run_transaction(input byte_t cmd, input byte_t regn, input logic [31:0] wdata);
      byte_t       reply [NOS_WRITE_BYTES];
      byte_t       exp_status;
      logic [31:0] exp_data;
      start_packet();
      send_byte(cmd);
      send_byte(regn);
      for (int i = 0; i < 4; i++)
         send_byte(wdata[8*i +: 8]);
      for (int i = 0; i < NOS_WRITE_BYTES; i++)
         take_byte(reply[i]);

      if (cmd[RESET_BIT]) begin
         exp_status = RESET_CMD_DONE;
         exp_data   = last_data;
      end else if (int'(regn) >= NUM_REGS) begin
         exp_status = CMD_ERROR;
         exp_data   = '0;
      end else begin
         exp_status = CMD_DONE;
         exp_data   = model_regs[regn[2:0]];   // Old value even on a write.
         if (cmd[RW_BIT])
            model_regs[regn[2:0]] = wdata;
      end
      last_data = exp_data;

      check_byte(UP_STATUS_REG, reply[UP_STATUS_REG], exp_status);
      for (int i = 1; i < NOS_WRITE_BYTES; i++)
         check_byte(i, reply[i], exp_data[8*(i-1) +: 8]);
   endtask

   initial begin
      logic [31:0] sel;
      logic [31:0] r;
      logic [31:0] wdata;
      byte_t       cmd;
      byte_t       regn;
      lfsr       = 16'd63281;
      errors     = 0;
      checks     = 0;
      model_regs = '{default: '0};
      last_data  = '0;
      reset          <= 1'b0;
      up_start       <= 1'b0;
      up_handshake_1 <= 1'b0;
      up_data_out    <= 8'h00;
      repeat (10) @(posedge clk);
      reset <= 1'b1;

      run_transaction(8'h01, 8'd3, 32'hA5C3_1E77);
      run_transaction(8'h00, 8'd3, 32'h0);
      run_transaction(8'h81, 8'd5, 32'h5A5A_0F0F);    // Soft reset ignores the write bit.
      run_transaction(8'h00, 8'd5, 32'h0);
      run_transaction(8'h01, 8'd9, 32'hDEAD_BEEF);    // Would alias register 1.
      run_transaction(8'h01, 8'd8, 32'h1234_5678);
      run_transaction(8'h00, 8'd1, 32'h0);
      run_transaction(8'h00, 8'd0, 32'h0);
      run_transaction(8'h00, 8'd3, 32'h0);

      for (int t = 0; t < NUM_RANDOM; t++) begin
         sel   = rand_bits(3);
         r     = rand_bits(4);
         wdata = rand_bits(32);
         cmd   = (sel == 0) ? 8'h80 : (sel < 4) ? 8'h00 : 8'h01;
         regn  = (r[3] && r[2]) ? byte_t'(r[3:0]) : byte_t'(r[2:0]);
         run_transaction(cmd, regn, wdata);
      end

      repeat (5) @(posedge clk);
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, UUT.u_checker.fail_count);
      if (errors == 0 && UUT.u_checker.fail_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
